/* logic/fwd_stall_defs.svh */
// Widths for an RV32I core with two EXE source operands; changing them resizes every struct
`ifndef FWD_STALL_DEFS_SVH
`define FWD_STALL_DEFS_SVH

// Architectural register address width, 32 integer registers
`define FS_REG_ADDR_W 5

// Integer data width
`define FS_XLEN 32

// Source operands read by the EXE stage (rs1 and rs2)
`define FS_NUM_SRC 2

`endif

/* logic/fwd_stall_pkg.sv */
// Shared types for the hazard unit; every struct is packed and sized by fwd_stall_defs.svh
`include "fwd_stall_defs.svh"

package fwd_stall_pkg;

    typedef logic [`FS_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`FS_XLEN-1:0]       xlen_t;

    // Outstanding long operation in the LSU stage
    typedef enum logic [1:0] {
        IDLE     = 2'b00,
        MEM_WAIT = 2'b01,
        MUL_WAIT = 2'b10
    } long_op_state_e;

    // EXE stage source operands and branch/jump redirect
    typedef struct packed {
        reg_addr_t [`FS_NUM_SRC-1:0] src_addr;
        logic [`FS_NUM_SRC-1:0]      src_used;
        logic                        new_pc_req;
    } exe2fwd_s;

    // LSU stage destination and long-operation handshakes
    typedef struct packed {
        reg_addr_t rd_addr;
        logic      rd_wr_req;
        logic      mem_req;
        logic      mem_ack;
        logic      mul_req;
        logic      mul_ack;
    } lsu2fwd_s;

    // Writeback stage destination
    typedef struct packed {
        reg_addr_t rd_addr;
        logic      rd_wr_req;
    } wrb2fwd_s;

    // CSR unit requests
    typedef struct packed {
        logic csr_read_req;
        logic new_pc_req;
        logic wfi_req;
        logic irq_flush_lsu;
    } csr2fwd_s;

    // Producer view shared by all comparators
    typedef struct packed {
        reg_addr_t lsu_rd_addr;
        logic      lsu_rd_wr;
        reg_addr_t wrb_rd_addr;
        logic      wrb_rd_wr;
        // Result in LSU is not available for forwarding this cycle
        logic      slow_result;
    } producer_s;

    // Classification of one EXE source
    typedef struct packed {
        logic fwd_lsu;
        logic fwd_wrb;
        logic ld_use;
    } src_hazard_s;

    // Requests towards fetch
    typedef struct packed {
        logic exe_new_pc_req;
        logic csr_new_pc_req;
        logic wfi_req;
        logic if_stall;
    } fwd2if_s;

    // Stage register controls
    typedef struct packed {
        logic if2id_stall;
        logic id2exe_stall;
        logic exe2lsu_stall;
        logic if2id_flush;
        logic id2exe_flush;
        logic exe2lsu_flush;
        logic lsu2wrb_flush;
    } pipe_ctrl_s;

    // Stall status towards the CSR unit
    typedef struct packed {
        logic pipe_stall;
        logic irq_stall;
    } fwd2csr_s;

endpackage : fwd_stall_pkg

/* logic/fwd_stall_top.sv */
// Hazard and forwarding unit of a 5-stage pipe; all outputs except fwd2csr_o are combinational
`include "fwd_stall_defs.svh"

module fwd_stall_top
    import fwd_stall_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  exe2fwd_s                exe2fwd_i,
    input  lsu2fwd_s                lsu2fwd_i,
    input  wrb2fwd_s                wrb2fwd_i,
    input  csr2fwd_s                csr2fwd_i,
    input  xlen_t [`FS_NUM_SRC-1:0] rf_data_i,
    input  xlen_t                   lsu_data_i,
    input  xlen_t                   wrb_data_i,
    output xlen_t [`FS_NUM_SRC-1:0] operand_o,
    output fwd2if_s                 fwd2if_o,
    output pipe_ctrl_s              pipe_ctrl_o,
    output fwd2csr_s                fwd2csr_o,
    output logic                    lsu_flush_o
);

    producer_s                     producer;
    logic                          long_op_stall;
    logic                          long_op_stall_q;
    src_hazard_s [`FS_NUM_SRC-1:0] hazards;

    long_op_tracker long_op_tracker_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .lsu2fwd_i         (lsu2fwd_i),
        .wrb2fwd_i         (wrb2fwd_i),
        .csr_read_req_i    (csr2fwd_i.csr_read_req),
        .flush_i           (lsu_flush_o),
        .producer_o        (producer),
        .long_op_stall_o   (long_op_stall),
        .long_op_stall_q_o (long_op_stall_q)
    );

    // One comparator per EXE source operand
    for (genvar k = 0; k < `FS_NUM_SRC; k++) begin : g_src
        operand_hazard_check operand_hazard_check_i (
            .src_addr_i      (exe2fwd_i.src_addr[k]),
            .src_used_i      (exe2fwd_i.src_used[k]),
            .producer_i      (producer),
            .long_op_stall_i (long_op_stall),
            .hazard_o        (hazards[k])
        );
    end

    pipe_ctrl pipe_ctrl_i (
        .hazards_i         (hazards),
        .long_op_stall_i   (long_op_stall),
        .long_op_stall_q_i (long_op_stall_q),
        .exe_new_pc_req_i  (exe2fwd_i.new_pc_req),
        .csr2fwd_i         (csr2fwd_i),
        .fwd2if_o          (fwd2if_o),
        .pipe_ctrl_o       (pipe_ctrl_o),
        .fwd2csr_o         (fwd2csr_o),
        .lsu_flush_o       (lsu_flush_o)
    );

    operand_fwd_mux operand_fwd_mux_i (
        .hazards_i  (hazards),
        .rf_data_i  (rf_data_i),
        .lsu_data_i (lsu_data_i),
        .wrb_data_i (wrb_data_i),
        .operand_o  (operand_o)
    );

endmodule : fwd_stall_top

/* logic/long_op_tracker.sv */
// Tracks one memory or multiply op at a time; a request is assumed to stay high until its ack
module long_op_tracker
    import fwd_stall_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  lsu2fwd_s  lsu2fwd_i,
    input  wrb2fwd_s  wrb2fwd_i,
    input  logic      csr_read_req_i,
    input  logic      flush_i,
    output producer_s producer_o,
    output logic      long_op_stall_o,
    output logic      long_op_stall_q_o
);

    long_op_state_e state_q;
    long_op_state_e state_next;
    logic           stall_q;

    // An ack ends the wait, otherwise a fresh request starts one
    always_comb begin
        state_next = state_q;

        case (state_q)
            MEM_WAIT: begin
                if (lsu2fwd_i.mem_ack) begin
                    state_next = IDLE;
                end
            end
            MUL_WAIT: begin
                if (lsu2fwd_i.mul_ack) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase

        // Memory wins when both units request in the same cycle
        if (state_next == IDLE) begin
            if (lsu2fwd_i.mem_req && !lsu2fwd_i.mem_ack) begin
                state_next = MEM_WAIT;
            end else if (lsu2fwd_i.mul_req && !lsu2fwd_i.mul_ack) begin
                state_next = MUL_WAIT;
            end
        end
    end

    assign long_op_stall_o = (state_next != IDLE);

    // CSR redirect or WFI abandons the pending operation
    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stall_q <= 1'b0;
        end else begin
            stall_q <= long_op_stall_o;
        end
    end

    assign long_op_stall_q_o = stall_q;

    always_comb begin
        producer_o.lsu_rd_addr = lsu2fwd_i.rd_addr;
        producer_o.lsu_rd_wr   = lsu2fwd_i.rd_wr_req;
        producer_o.wrb_rd_addr = wrb2fwd_i.rd_addr;
        producer_o.wrb_rd_wr   = wrb2fwd_i.rd_wr_req;
        // Load data, product and CSR value arrive only in writeback
        producer_o.slow_result = lsu2fwd_i.mem_req | lsu2fwd_i.mul_req | csr_read_req_i;
    end

endmodule : long_op_tracker

/* logic/operand_fwd_mux.sv */
// Operand select assumes at most one of fwd_lsu and fwd_wrb is set per source
`include "fwd_stall_defs.svh"

module operand_fwd_mux
    import fwd_stall_pkg::*;
(
    input  src_hazard_s [`FS_NUM_SRC-1:0] hazards_i,
    input  xlen_t [`FS_NUM_SRC-1:0]       rf_data_i,
    input  xlen_t                         lsu_data_i,
    input  xlen_t                         wrb_data_i,
    output xlen_t [`FS_NUM_SRC-1:0]       operand_o
);

    always_comb begin
        for (int k = 0; k < `FS_NUM_SRC; k++) begin
            // Most recent producer first
            if (hazards_i[k].fwd_lsu) begin
                operand_o[k] = lsu_data_i;
            end else if (hazards_i[k].fwd_wrb) begin
                operand_o[k] = wrb_data_i;
            end else begin
                operand_o[k] = rf_data_i[k];
            end
        end
    end

endmodule : operand_fwd_mux

/* logic/operand_hazard_check.sv */
// One comparator per EXE source; x0 is hardwired to zero and never matches
module operand_hazard_check
    import fwd_stall_pkg::*;
(
    input  reg_addr_t   src_addr_i,
    input  logic        src_used_i,
    input  producer_s   producer_i,
    input  logic        long_op_stall_i,
    output src_hazard_s hazard_o
);

    logic src_valid;
    logic lsu_match;
    logic wrb_match;

    assign src_valid = |src_addr_i;

    assign lsu_match = src_valid && producer_i.lsu_rd_wr
                       && (src_addr_i == producer_i.lsu_rd_addr);
    assign wrb_match = src_valid && producer_i.wrb_rd_wr
                       && (src_addr_i == producer_i.wrb_rd_addr);

    // Younger producer in LSU shadows the one in writeback
    assign hazard_o.fwd_lsu = lsu_match && !producer_i.slow_result;
    assign hazard_o.fwd_wrb = wrb_match && !lsu_match;

    // Slow result in LSU needs a bubble, unless the pipe is already held
    assign hazard_o.ld_use  = lsu_match && producer_i.slow_result && src_used_i
                              && !long_op_stall_i;

endmodule : operand_hazard_check

/* logic/pipe_ctrl.sv */
// Stall and flush strobes are combinational; a CSR redirect or WFI always overrides EXE
`include "fwd_stall_defs.svh"

module pipe_ctrl
    import fwd_stall_pkg::*;
(
    input  src_hazard_s [`FS_NUM_SRC-1:0] hazards_i,
    input  logic                          long_op_stall_i,
    input  logic                          long_op_stall_q_i,
    input  logic                          exe_new_pc_req_i,
    input  csr2fwd_s                      csr2fwd_i,
    output fwd2if_s                       fwd2if_o,
    output pipe_ctrl_s                    pipe_ctrl_o,
    output fwd2csr_s                      fwd2csr_o,
    output logic                          lsu_flush_o
);

    logic ld_use_hazard;
    logic exe_pc_req;
    logic csr_flush;
    logic front_flush;
    logic front_stall;

    always_comb begin
        ld_use_hazard = 1'b0;
        for (int k = 0; k < `FS_NUM_SRC; k++) begin
            ld_use_hazard = ld_use_hazard | hazards_i[k].ld_use;
        end
    end

    // Branch outcome in EXE is only valid once its operands are
    assign exe_pc_req  = exe_new_pc_req_i && !(ld_use_hazard || long_op_stall_i);

    assign csr_flush   = csr2fwd_i.new_pc_req | csr2fwd_i.wfi_req;
    assign front_flush = exe_pc_req | csr_flush;
    assign front_stall = ld_use_hazard | long_op_stall_i;

    assign lsu_flush_o = csr_flush;

    always_comb begin
        pipe_ctrl_o.if2id_stall   = front_stall;
        pipe_ctrl_o.id2exe_stall  = front_stall;
        pipe_ctrl_o.exe2lsu_stall = long_op_stall_i;
        pipe_ctrl_o.if2id_flush   = front_flush;
        pipe_ctrl_o.id2exe_flush  = front_flush;
        // Bubble behind the dependent instruction
        pipe_ctrl_o.exe2lsu_flush = ld_use_hazard | csr_flush;
        pipe_ctrl_o.lsu2wrb_flush = csr2fwd_i.irq_flush_lsu;
    end

    always_comb begin
        fwd2if_o.exe_new_pc_req = exe_pc_req && !csr2fwd_i.new_pc_req;
        fwd2if_o.csr_new_pc_req = csr2fwd_i.new_pc_req;
        fwd2if_o.wfi_req        = csr2fwd_i.wfi_req;
        fwd2if_o.if_stall       = front_stall;
    end

    // Interrupt entry waits while any stage is held
    always_comb begin
        fwd2csr_o.pipe_stall = long_op_stall_q_i;
        fwd2csr_o.irq_stall  = front_stall | long_op_stall_q_i;
    end

endmodule : pipe_ctrl

/* src.f */
+incdir+logic
logic/fwd_stall_pkg.sv
logic/long_op_tracker.sv
logic/operand_hazard_check.sv
logic/pipe_ctrl.sv
logic/operand_fwd_mux.sv
logic/fwd_stall_top.sv
verification/fwd_stall_sva.sv
verification/fwd_stall_tb.sv

/* verification/fwd_stall_sva.sv */
// Bound into fwd_stall_top; checks stall and flush invariants only while reset is released
`include "fwd_stall_defs.svh"

module fwd_stall_sva
    import fwd_stall_pkg::*;
(
    input logic                          clk,
    input logic                          rst_n,
    input src_hazard_s [`FS_NUM_SRC-1:0] hazards_i,
    input fwd2if_s                       fwd2if_i,
    input pipe_ctrl_s                    pipe_ctrl_i,
    input fwd2csr_s                      fwd2csr_i
);

    timeunit 1ns;
    timeprecision 1ps;

    logic        any_ld_use;
    // Number of failed assertions so far
    int unsigned assert_errors;

    always_comb begin
        any_ld_use = 1'b0;
        for (int k = 0; k < `FS_NUM_SRC; k++) begin
            any_ld_use = any_ld_use | hazards_i[k].ld_use;
        end
    end

    // Tracker and registered stall both come out of reset idle
    no_stall_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !(pipe_ctrl_i.if2id_stall || pipe_ctrl_i.id2exe_stall
                           || pipe_ctrl_i.exe2lsu_stall || fwd2if_i.if_stall
                           || fwd2csr_i.pipe_stall || fwd2csr_i.irq_stall))
        else begin
            $error("Stall output active in the first cycle after reset");
            assert_errors++;
        end

    pc_req_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(fwd2if_i.exe_new_pc_req && fwd2if_i.csr_new_pc_req))
        else begin
            $error("EXE and CSR PC requests raised together");
            assert_errors++;
        end

    stall_q_follows: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> fwd2csr_i.pipe_stall == $past(pipe_ctrl_i.exe2lsu_stall))
        else begin
            $error("Registered stall does not follow the EXE/LSU stall");
            assert_errors++;
        end

    ld_use_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        any_ld_use |-> pipe_ctrl_i.exe2lsu_flush)
        else begin
            $error("Load-use hazard without EXE/LSU flush");
            assert_errors++;
        end

endmodule : fwd_stall_sva

bind fwd_stall_top fwd_stall_sva fwd_stall_sva_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .hazards_i   (hazards),
    .fwd2if_i    (fwd2if_o),
    .pipe_ctrl_i (pipe_ctrl_o),
    .fwd2csr_i   (fwd2csr_o)
);

/* verification/fwd_stall_tb.sv */
// Run from the project root so verification/fwd_stall_tests.dat is found; RF words are random
`include "fwd_stall_defs.svh"

module fwd_stall_tb
    import fwd_stall_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 4;
    localparam int IDLE_TIMEOUT = 10;
    localparam int MAX_CYCLES   = 200;

    logic                    clk;
    logic                    rst_n;
    exe2fwd_s                exe2fwd;
    lsu2fwd_s                lsu2fwd;
    wrb2fwd_s                wrb2fwd;
    csr2fwd_s                csr2fwd;
    xlen_t [`FS_NUM_SRC-1:0] rf_data;
    xlen_t                   lsu_data;
    xlen_t                   wrb_data;
    xlen_t [`FS_NUM_SRC-1:0] operand;
    fwd2if_s                 fwd2if;
    pipe_ctrl_s              pipe_ctrl;
    fwd2csr_s                fwd2csr;
    logic                    lsu_flush;

    // One vector as read from the data file
    int          v_test;
    reg_addr_t   v_rs1;
    reg_addr_t   v_rs2;
    reg_addr_t   v_lsu_rd;
    reg_addr_t   v_wrb_rd;
    logic [1:0]  v_used;
    logic [1:0]  v_csr_o;
    logic        v_exe_pc;
    logic        v_lsu_wr;
    logic        v_wrb_wr;
    logic        v_lsu_flush;
    logic [3:0]  v_hs;
    logic [3:0]  v_csr;
    logic [3:0]  v_fetch;
    logic [31:0] v_lsu_data;
    logic [31:0] v_wrb_data;
    int          v_sel0;
    int          v_sel1;
    logic [6:0]  v_pipe;

    integer seed;
    int     fd;
    int     code;
    int     cycles;
    int     wait_cycles;
    int     cur_test;
    int     test_errors;
    int     test_vectors;
    int     tests_passed;
    int     tests_failed;
    bit     have_test;
    bit     aborted;
    string  line;

    fwd_stall_top fwd_stall_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .exe2fwd_i   (exe2fwd),
        .lsu2fwd_i   (lsu2fwd),
        .wrb2fwd_i   (wrb2fwd),
        .csr2fwd_i   (csr2fwd),
        .rf_data_i   (rf_data),
        .lsu_data_i  (lsu_data),
        .wrb_data_i  (wrb_data),
        .operand_o   (operand),
        .fwd2if_o    (fwd2if),
        .pipe_ctrl_o (pipe_ctrl),
        .fwd2csr_o   (fwd2csr),
        .lsu_flush_o (lsu_flush)
    );

    always #HALF_PERIOD clk = ~clk;

    // Select code 0 picks the RF word, 1 the LSU result, 2 the WRB result
    function automatic xlen_t expected_operand(int sel, xlen_t rf_word);
        if (sel == 1) begin
            return v_lsu_data;
        end else if (sel == 2) begin
            return v_wrb_data;
        end
        return rf_word;
    endfunction

    task automatic compare_value(string name, logic [31:0] exp, logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] %0d ns test %0d %s expected %h got %h",
                     $time, cur_test, name, exp, act);
            test_errors++;
        end
    endtask

    task automatic close_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d ok over %0d vectors", cur_test, test_vectors);
        end else begin
            tests_failed++;
            $display("test %0d bad, %0d mismatches over %0d vectors",
                     cur_test, test_errors, test_vectors);
        end
        test_errors  = 0;
        test_vectors = 0;
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        exe2fwd  = '0;
        lsu2fwd  = '0;
        wrb2fwd  = '0;
        csr2fwd  = '0;
        rf_data  = '0;
        lsu_data = '0;
        wrb_data = '0;
        seed     = 32'heb90_c0ae;

        cycles = 0;
        while (cycles < RESET_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        rst_n = 1'b1;

        // Outputs must settle idle once reset is gone
        wait_cycles = 0;
        while ((pipe_ctrl !== '0 || fwd2if !== '0 || fwd2csr !== '0)
               && wait_cycles < IDLE_TIMEOUT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (wait_cycles >= IDLE_TIMEOUT) begin
            $display("Outputs did not go idle within %0d cycles after reset", IDLE_TIMEOUT);
            aborted = 1'b1;
        end

        fd = $fopen("verification/fwd_stall_tests.dat", "r");
        if (fd == 0) begin
            $display("Could not open the vector file");
            aborted = 1'b1;
        end

        cycles = 0;
        while (!aborted && !$feof(fd)) begin
            if (cycles >= MAX_CYCLES) begin
                $display("Vector loop still running after %0d cycles", MAX_CYCLES);
                aborted = 1'b1;
                break;
            end
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            code = $sscanf(line, "%d %d %d %b %b %d %b %b %d %b %b %h %h %d %d %b %b %b %b",
                           v_test, v_rs1, v_rs2, v_used, v_exe_pc, v_lsu_rd, v_lsu_wr,
                           v_hs, v_wrb_rd, v_wrb_wr, v_csr, v_lsu_data, v_wrb_data,
                           v_sel0, v_sel1, v_pipe, v_fetch, v_csr_o, v_lsu_flush);
            if (code != 19) begin
                $display("Malformed vector line: %s", line);
                aborted = 1'b1;
                break;
            end
            if (have_test && v_test != cur_test) begin
                close_test();
            end
            have_test = 1'b1;
            cur_test  = v_test;

            @(negedge clk);
            exe2fwd.src_addr[0] = v_rs1;
            exe2fwd.src_addr[1] = v_rs2;
            exe2fwd.src_used    = v_used;
            exe2fwd.new_pc_req  = v_exe_pc;
            lsu2fwd             = {v_lsu_rd, v_lsu_wr, v_hs};
            wrb2fwd             = {v_wrb_rd, v_wrb_wr};
            csr2fwd             = v_csr;
            lsu_data            = v_lsu_data;
            wrb_data            = v_wrb_data;
            for (int k = 0; k < `FS_NUM_SRC; k++) begin
                rf_data[k] = $random(seed);
            end

            // Sample shortly before the rising edge
            #(HALF_PERIOD - 2);
            compare_value("operand_o[0]", expected_operand(v_sel0, rf_data[0]), operand[0]);
            compare_value("operand_o[1]", expected_operand(v_sel1, rf_data[1]), operand[1]);
            compare_value("pipe_ctrl_o", v_pipe, pipe_ctrl);
            compare_value("fwd2if_o", v_fetch, fwd2if);
            compare_value("fwd2csr_o", v_csr_o, fwd2csr);
            compare_value("lsu_flush_o", v_lsu_flush, lsu_flush);
            test_vectors++;
            cycles++;
        end

        if (fd != 0) begin
            $fclose(fd);
        end
        if (have_test) begin
            close_test();
        end else begin
            $display("No vectors were read");
            aborted = 1'b1;
        end

        $display("Tests passed %0d, tests failed %0d, assertion failures %0d",
                 tests_passed, tests_failed, fwd_stall_top_i.fwd_stall_sva_i.assert_errors);
        if (!aborted && tests_failed == 0
            && fwd_stall_top_i.fwd_stall_sva_i.assert_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : fwd_stall_tb

/* verification/fwd_stall_tests.dat */
# test rs1 rs2 used{rs2,rs1} exe_pc lsu_rd lsu_wr {mreq mack ureq uack} wrb_rd wrb_wr {rd pc wfi irq}
# lsu_data wrb_data then expected: sel0 sel1 (0 rf 1 lsu 2 wrb) pipe_ctrl fwd2if fwd2csr lsu_flush
1 0 0 00 0 0 0 0000 0 0 0000 00000000 00000000 0 0 0000000 0000 00 0
1 0 0 00 0 0 0 0000 0 0 0000 3c1a9e07 b04d52e1 0 0 0000000 0000 00 0
2 5 7 11 0 5 1 0000 7 1 0000 1f2e3d4c 5a6b7c8d 1 2 0000000 0000 00 0
2 9 9 11 0 9 1 0000 9 1 0000 d00dfeed 0badcafe 1 1 0000000 0000 00 0
2 0 3 11 0 0 1 0000 0 1 0000 77665544 33221100 0 0 0000000 0000 00 0
2 4 4 11 0 4 0 0000 4 0 0000 12345678 9abcdef0 0 0 0000000 0000 00 0
3 6 0 01 0 6 1 1100 0 0 0000 6e2f0a91 c4d3b2a1 0 0 1100010 0001 01 0
3 0 6 10 0 6 1 0011 0 0 0000 0f1e2d3c 8899aabb 0 0 1100010 0001 01 0
3 6 0 01 0 6 1 0000 0 0 1000 45e1c3a7 19283746 0 0 1100010 0001 01 0
3 6 0 00 0 6 1 0000 0 0 1000 a0b1c2d3 e4f50617 0 0 0000000 0000 00 0
4 8 0 01 0 8 1 1000 0 0 0000 5566aa11 2233cc44 0 0 1110000 0001 01 0
4 8 0 01 0 8 1 1000 0 0 0000 5566aa12 2233cc45 0 0 1110000 0001 11 0
4 8 0 01 0 8 1 1000 0 0 0000 5566aa13 2233cc46 0 0 1110000 0001 11 0
4 0 0 00 0 8 1 1100 0 0 0000 5566aa14 2233cc47 0 0 0000000 0000 11 0
4 0 0 00 0 0 0 0000 0 0 0000 5566aa15 2233cc48 0 0 0000000 0000 00 0
5 0 0 00 0 0 0 0010 0 0 0000 7d3c9b21 e8a64f02 0 0 1110000 0001 01 0
5 0 0 00 0 0 0 0010 0 0 0000 7d3c9b22 e8a64f03 0 0 1110000 0001 11 0
5 0 0 00 0 0 0 0011 0 0 0000 7d3c9b23 e8a64f04 0 0 0000000 0000 11 0
5 0 0 00 0 0 0 0000 0 0 0000 7d3c9b24 e8a64f05 0 0 0000000 0000 00 0
6 0 0 00 1 0 0 0000 0 0 0000 b1e2d3c4 4c3d2e1f 0 0 0001100 1000 00 0
6 6 0 01 1 6 1 1100 0 0 0000 b1e2d3c5 4c3d2e20 0 0 1100010 0001 01 0
6 0 0 00 1 0 0 0000 0 0 0100 b1e2d3c6 4c3d2e21 0 0 0001110 0100 00 1
6 0 0 00 1 0 0 1000 0 0 0000 b1e2d3c7 4c3d2e22 0 0 1110000 0001 01 0
7 0 0 00 0 0 0 1000 0 0 0010 a1b2c3d4 e5f60718 0 0 1111110 0011 11 1
7 0 0 00 0 0 0 0000 0 0 0000 a1b2c3d5 e5f60719 0 0 0000000 0000 11 0
7 0 0 00 0 0 0 0000 0 0 0000 a1b2c3d6 e5f6071a 0 0 0000000 0000 00 0
8 0 0 00 0 0 0 0000 0 0 0001 f00d1234 beef5678 0 0 0000001 0000 00 0
